// File: Bender.yml
package:
  name: exec_stage

sources:
  - source/rv_pkg.sv
  - source/instr_decoder.sv
  - source/register_file.sv
  - source/exec_alu.sv
  - source/exec_stage.sv
  - target: simulation
    files:
      - verification/exec_stage_asserts.sv
      - verification/exec_stage_tb.sv

// File: source/exec_alu.sv
`timescale 1ns/10ps

module exec_alu (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    issue,
   input  logic [rv_pkg::op_w-1:0] op,
   input  logic [rv_pkg::xlen-1:0] pc,
   input  logic [rv_pkg::xlen-1:0] imm,
   input  logic [4:0]              rs1_idx,
   input  logic [4:0]              rs2_idx,
   input  logic [4:0]              rd_idx,
   input  logic [rv_pkg::xlen-1:0] rs1_data,
   input  logic [rv_pkg::xlen-1:0] rs2_data,
   input  logic                    illegal_in,
   input  logic                    mem_fwd_en,
   input  logic [4:0]              mem_fwd_rd,
   input  logic [rv_pkg::xlen-1:0] mem_fwd_value,
   output logic                    completed,
   output logic [rv_pkg::xlen-1:0] result,
   output logic [4:0]              rd_out,
   output logic                    illegal
);
   import rv_pkg::*;

   logic [xlen-1:0]   a;
   logic [xlen-1:0]   b;
   logic [xlen-1:0]   res;
   logic [2*xlen-1:0] prod_ss;
   logic [2*xlen-1:0] prod_su;
   logic [2*xlen-1:0] prod_uu;
   logic              div_zero;
   logic              div_ovf;

   // own result first, then the memory stage, then the register file
   function automatic logic [xlen-1:0] pick_operand(input logic [4:0] idx,
                                                    input logic [xlen-1:0] rf_value);
      if (completed && !illegal && rd_out != 5'd0 && rd_out == idx) begin
         return result;
      end else if (mem_fwd_en && mem_fwd_rd != 5'd0 && mem_fwd_rd == idx) begin
         return mem_fwd_value;
      end
      return rf_value;
   endfunction

   always_comb begin
      a = pick_operand(rs1_idx, rs1_data);
      b = pick_operand(rs2_idx, rs2_data);
   end

   assign prod_ss = $signed({{xlen{a[xlen-1]}}, a}) * $signed({{xlen{b[xlen-1]}}, b});
   assign prod_su = $signed({{xlen{a[xlen-1]}}, a}) * $signed({{xlen{1'b0}}, b});
   assign prod_uu = {{xlen{1'b0}}, a} * {{xlen{1'b0}}, b};

   assign div_zero = (b == '0);
   // most negative divided by -1
   assign div_ovf = (a == {1'b1, {(xlen-1){1'b0}}}) && (b == '1);

   always_comb begin
      res = '0;
      case (op)
         op_lui: res = imm;
         op_auipc: res = pc + imm;
         op_jal, op_jalr: res = pc + 32'd4;
         op_beq: res = {{(xlen-1){1'b0}}, a == b};
         op_bne: res = {{(xlen-1){1'b0}}, a != b};
         op_blt: res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
         op_bge: res = {{(xlen-1){1'b0}}, $signed(a) >= $signed(b)};
         op_bltu: res = {{(xlen-1){1'b0}}, a < b};
         op_bgeu: res = {{(xlen-1){1'b0}}, a >= b};
         // effective address
         op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw: res = a + imm;
         op_addi: res = a + imm;
         op_slti: res = {{(xlen-1){1'b0}}, $signed(a) < $signed(imm)};
         op_sltiu: res = {{(xlen-1){1'b0}}, a < imm};
         op_xori: res = a ^ imm;
         op_ori: res = a | imm;
         op_andi: res = a & imm;
         op_slli: res = a << imm[4:0];
         op_srli: res = a >> imm[4:0];
         op_srai: res = $signed(a) >>> imm[4:0];
         op_add: res = a + b;
         op_sub: res = a - b;
         op_sll: res = a << b[4:0];
         op_slt: res = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
         op_sltu: res = {{(xlen-1){1'b0}}, a < b};
         op_xor: res = a ^ b;
         op_srl: res = a >> b[4:0];
         op_sra: res = $signed(a) >>> b[4:0];
         op_or: res = a | b;
         op_and: res = a & b;
         op_mul: res = prod_ss[xlen-1:0];
         op_mulh: res = prod_ss[2*xlen-1:xlen];
         op_mulhsu: res = prod_su[2*xlen-1:xlen];
         op_mulhu: res = prod_uu[2*xlen-1:xlen];
         op_div: begin
            if (div_zero) res = '1;
            else if (div_ovf) res = a;
            else res = $signed(a) / $signed(b);
         end
         op_divu: res = div_zero ? '1 : a / b;
         op_rem: begin
            if (div_zero) res = a;
            else if (div_ovf) res = '0;
            else res = $signed(a) % $signed(b);
         end
         op_remu: res = div_zero ? a : a % b;
         default: res = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         completed <= 1'b0;
      end else begin
         completed <= issue;
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         result <= res;
         rd_out <= rd_idx;
         illegal <= illegal_in;
      end
   end

endmodule

// File: source/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    issue,
   input  logic [rv_pkg::xlen-1:0] instr,
   input  logic [rv_pkg::xlen-1:0] pc,
   input  logic                    mem_fwd_en,
   input  logic [4:0]              mem_fwd_rd,
   input  logic [rv_pkg::xlen-1:0] mem_fwd_value,
   output logic                    completed,
   output logic [rv_pkg::xlen-1:0] result,
   output logic [4:0]              rd_out,
   output logic                    illegal
);
   import rv_pkg::*;

   logic [op_w-1:0] op;
   logic [4:0]      rs1_idx;
   logic [4:0]      rs2_idx;
   logic [4:0]      rd_idx;
   logic [xlen-1:0] imm;
   logic            dec_illegal;
   logic [xlen-1:0] rs1_data;
   logic [xlen-1:0] rs2_data;
   logic            wr_en;

   // write-back of the registered result
   assign wr_en = completed && !illegal;

   instr_decoder u_decoder (
      .instr   (instr),
      .op      (op),
      .rs1_idx (rs1_idx),
      .rs2_idx (rs2_idx),
      .rd_idx  (rd_idx),
      .imm     (imm),
      .illegal (dec_illegal)
   );

   register_file u_regs (
      .clk      (clk),
      .rstn     (rstn),
      .rs1_idx  (rs1_idx),
      .rs2_idx  (rs2_idx),
      .rs1_data (rs1_data),
      .rs2_data (rs2_data),
      .wr_en    (wr_en),
      .wr_idx   (rd_out),
      .wr_data  (result)
   );

   exec_alu u_alu (
      .clk           (clk),
      .rstn          (rstn),
      .issue         (issue),
      .op            (op),
      .pc            (pc),
      .imm           (imm),
      .rs1_idx       (rs1_idx),
      .rs2_idx       (rs2_idx),
      .rd_idx        (rd_idx),
      .rs1_data      (rs1_data),
      .rs2_data      (rs2_data),
      .illegal_in    (dec_illegal),
      .mem_fwd_en    (mem_fwd_en),
      .mem_fwd_rd    (mem_fwd_rd),
      .mem_fwd_value (mem_fwd_value),
      .completed     (completed),
      .result        (result),
      .rd_out        (rd_out),
      .illegal       (illegal)
   );

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
   input  rv_pkg::instr_word_u     instr,
   output logic [rv_pkg::op_w-1:0] op,
   output logic [4:0]              rs1_idx,
   output logic [4:0]              rs2_idx,
   output logic [4:0]              rd_idx,
   output logic [rv_pkg::xlen-1:0] imm,
   output logic                    illegal
);
   import rv_pkg::*;

   logic [2:0]      f3;
   logic [6:0]      f7;
   logic [xlen-1:0] imm_i;
   logic [xlen-1:0] imm_s;
   logic [xlen-1:0] imm_b;
   logic [xlen-1:0] imm_u;
   logic [xlen-1:0] imm_j;

   assign f3 = instr.r.funct3;
   assign f7 = instr.r.funct7;

   // sign-extended immediates per format
   assign imm_i = {{20{instr.i.imm11_0[11]}}, instr.i.imm11_0};
   assign imm_s = {{20{instr.s.imm11_5[6]}}, instr.s.imm11_5, instr.s.imm4_0};
   assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                   instr.b.imm10_5, instr.b.imm4_1, 1'b0};
   assign imm_u = {instr.u.imm31_12, 12'b0};
   assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                   instr.j.imm11, instr.j.imm10_1, 1'b0};

   always_comb begin
      op = op_add;
      rs1_idx = instr.r.rs1;
      rs2_idx = instr.r.rs2;
      rd_idx = instr.r.rd;
      imm = '0;
      illegal = 1'b0;
      case (instr.r.opcode)
         opc_lui, opc_auipc: begin
            op = (instr.u.opcode == opc_lui) ? op_lui : op_auipc;
            rs1_idx = '0;
            rs2_idx = '0;
            imm = imm_u;
         end
         opc_jal: begin
            op = op_jal;
            rs1_idx = '0;
            rs2_idx = '0;
            imm = imm_j;
         end
         opc_jalr: begin
            op = op_jalr;
            rs2_idx = '0;
            imm = imm_i;
            illegal = (f3 != 3'd0);
         end
         opc_branch: begin
            // no destination
            rd_idx = '0;
            imm = imm_b;
            case (f3)
               3'd0: op = op_beq;
               3'd1: op = op_bne;
               3'd4: op = op_blt;
               3'd5: op = op_bge;
               3'd6: op = op_bltu;
               3'd7: op = op_bgeu;
               default: illegal = 1'b1;
            endcase
         end
         opc_load: begin
            rs2_idx = '0;
            imm = imm_i;
            case (f3)
               3'd0: op = op_lb;
               3'd1: op = op_lh;
               3'd2: op = op_lw;
               3'd4: op = op_lbu;
               3'd5: op = op_lhu;
               default: illegal = 1'b1;
            endcase
         end
         opc_store: begin
            rd_idx = '0;
            imm = imm_s;
            case (f3)
               3'd0: op = op_sb;
               3'd1: op = op_sh;
               3'd2: op = op_sw;
               default: illegal = 1'b1;
            endcase
         end
         opc_op_imm: begin
            rs2_idx = '0;
            imm = imm_i;
            case (f3)
               3'd0: op = op_addi;
               3'd2: op = op_slti;
               3'd3: op = op_sltiu;
               3'd4: op = op_xori;
               3'd6: op = op_ori;
               3'd7: op = op_andi;
               3'd1: begin
                  op = op_slli;
                  illegal = (f7 != funct7_base);
               end
               default: begin
                  // srli or srai by funct7
                  op = (f7 == funct7_alt) ? op_srai : op_srli;
                  illegal = (f7 != funct7_base) && (f7 != funct7_alt);
               end
            endcase
         end
         opc_op: begin
            if (f7 == funct7_m) begin
               case (f3)
                  3'd0: op = op_mul;
                  3'd1: op = op_mulh;
                  3'd2: op = op_mulhsu;
                  3'd3: op = op_mulhu;
                  3'd4: op = op_div;
                  3'd5: op = op_divu;
                  3'd6: op = op_rem;
                  default: op = op_remu;
               endcase
            end else if (f7 == funct7_base) begin
               case (f3)
                  3'd0: op = op_add;
                  3'd1: op = op_sll;
                  3'd2: op = op_slt;
                  3'd3: op = op_sltu;
                  3'd4: op = op_xor;
                  3'd5: op = op_srl;
                  3'd6: op = op_or;
                  default: op = op_and;
               endcase
            end else if (f7 == funct7_alt && f3 == 3'd0) begin
               op = op_sub;
            end else if (f7 == funct7_alt && f3 == 3'd5) begin
               op = op_sra;
            end else begin
               illegal = 1'b1;
            end
         end
         default: illegal = 1'b1;
      endcase
      // unknown encodings become a harmless add with no write
      if (illegal) begin
         op = op_add;
         rd_idx = '0;
      end
   end

endmodule

// File: source/register_file.sv
`timescale 1ns/10ps

module register_file (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic [4:0]              rs1_idx,
   input  logic [4:0]              rs2_idx,
   output logic [rv_pkg::xlen-1:0] rs1_data,
   output logic [rv_pkg::xlen-1:0] rs2_data,
   input  logic                    wr_en,
   input  logic [4:0]              wr_idx,
   input  logic [rv_pkg::xlen-1:0] wr_data
);
   import rv_pkg::*;

   // x0 has no storage
   logic [xlen-1:0] regs [1:31];

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en && wr_idx != 5'd0) begin
         regs[wr_idx] <= wr_data;
      end
   end

   assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
   assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// File: source/rv_pkg.sv
package rv_pkg;

   localparam int xlen = 32;
   localparam int op_w = 6;

   // major opcodes
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_load   = 7'b0000011;
   localparam logic [6:0] opc_store  = 7'b0100011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_op     = 7'b0110011;

   localparam logic [6:0] funct7_base = 7'b0000000;
   // sub, sra, srai
   localparam logic [6:0] funct7_alt  = 7'b0100000;
   localparam logic [6:0] funct7_m    = 7'b0000001;

   // operation codes
   localparam logic [op_w-1:0] op_add    = 6'd0;
   localparam logic [op_w-1:0] op_sub    = 6'd1;
   localparam logic [op_w-1:0] op_sll    = 6'd2;
   localparam logic [op_w-1:0] op_slt    = 6'd3;
   localparam logic [op_w-1:0] op_sltu   = 6'd4;
   localparam logic [op_w-1:0] op_xor    = 6'd5;
   localparam logic [op_w-1:0] op_srl    = 6'd6;
   localparam logic [op_w-1:0] op_sra    = 6'd7;
   localparam logic [op_w-1:0] op_or     = 6'd8;
   localparam logic [op_w-1:0] op_and    = 6'd9;
   localparam logic [op_w-1:0] op_addi   = 6'd10;
   localparam logic [op_w-1:0] op_slti   = 6'd11;
   localparam logic [op_w-1:0] op_sltiu  = 6'd12;
   localparam logic [op_w-1:0] op_xori   = 6'd13;
   localparam logic [op_w-1:0] op_ori    = 6'd14;
   localparam logic [op_w-1:0] op_andi   = 6'd15;
   localparam logic [op_w-1:0] op_slli   = 6'd16;
   localparam logic [op_w-1:0] op_srli   = 6'd17;
   localparam logic [op_w-1:0] op_srai   = 6'd18;
   localparam logic [op_w-1:0] op_lui    = 6'd19;
   localparam logic [op_w-1:0] op_auipc  = 6'd20;
   localparam logic [op_w-1:0] op_jal    = 6'd21;
   localparam logic [op_w-1:0] op_jalr   = 6'd22;
   localparam logic [op_w-1:0] op_beq    = 6'd23;
   localparam logic [op_w-1:0] op_bne    = 6'd24;
   localparam logic [op_w-1:0] op_blt    = 6'd25;
   localparam logic [op_w-1:0] op_bge    = 6'd26;
   localparam logic [op_w-1:0] op_bltu   = 6'd27;
   localparam logic [op_w-1:0] op_bgeu   = 6'd28;
   localparam logic [op_w-1:0] op_lb     = 6'd29;
   localparam logic [op_w-1:0] op_lh     = 6'd30;
   localparam logic [op_w-1:0] op_lw     = 6'd31;
   localparam logic [op_w-1:0] op_lbu    = 6'd32;
   localparam logic [op_w-1:0] op_lhu    = 6'd33;
   localparam logic [op_w-1:0] op_sb     = 6'd34;
   localparam logic [op_w-1:0] op_sh     = 6'd35;
   localparam logic [op_w-1:0] op_sw     = 6'd36;
   localparam logic [op_w-1:0] op_mul    = 6'd37;
   localparam logic [op_w-1:0] op_mulh   = 6'd38;
   localparam logic [op_w-1:0] op_mulhsu = 6'd39;
   localparam logic [op_w-1:0] op_mulhu  = 6'd40;
   localparam logic [op_w-1:0] op_div    = 6'd41;
   localparam logic [op_w-1:0] op_divu   = 6'd42;
   localparam logic [op_w-1:0] op_rem    = 6'd43;
   localparam logic [op_w-1:0] op_remu   = 6'd44;

   // one instruction word, seen through each format
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } r;
      struct packed {
         logic [11:0] imm11_0;
         logic [4:0]  rs1;
         logic [2:0]  funct3;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } i;
      struct packed {
         logic [6:0] imm11_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] imm4_0;
         logic [6:0] opcode;
      } s;
      struct packed {
         logic       imm12;
         logic [5:0] imm10_5;
         logic [4:0] rs2;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [3:0] imm4_1;
         logic       imm11;
         logic [6:0] opcode;
      } b;
      struct packed {
         logic [19:0] imm31_12;
         logic [4:0]  rd;
         logic [6:0]  opcode;
      } u;
      struct packed {
         logic       imm20;
         logic [9:0] imm10_1;
         logic       imm11;
         logic [7:0] imm19_12;
         logic [4:0] rd;
         logic [6:0] opcode;
      } j;
      logic [xlen-1:0] raw;
   } instr_word_u;

endpackage

// File: verification/exec_stage_asserts.sv
`timescale 1ns/10ps

module exec_stage_asserts (
   input logic        clk,
   input logic        rstn,
   input logic        issue,
   input logic        completed,
   input logic        dec_illegal,
   input logic        wr_en,
   input logic [4:0]  rs1_idx,
   input logic [31:0] rs1_value,
   input logic [4:0]  rs2_idx,
   input logic [31:0] rs2_value
);

   int fails = 0;

   // one pulse one cycle after each issue
   completion_follows_issue: assert property (
      @(posedge clk) disable iff (rstn) issue |=> completed)
      else begin
         fails++;
         $error("completed missing one cycle after issue");
      end

   no_completion_without_issue: assert property (
      @(posedge clk) disable iff (rstn) !issue |=> !completed)
      else begin
         fails++;
         $error("completed high without an issue");
      end

   // an illegal issue must not write back on completion
   no_write_when_illegal: assert property (
      @(posedge clk) disable iff (rstn) issue && dec_illegal |=> !wr_en)
      else begin
         fails++;
         $error("register write with illegal set");
      end

   // operands after forwarding
   x0_reads_zero: assert property (
      @(posedge clk) (rs1_idx == 5'd0 |-> rs1_value == '0)
                     and (rs2_idx == 5'd0 |-> rs2_value == '0))
      else begin
         fails++;
         $error("x0 read returned nonzero data");
      end

endmodule

// File: verification/exec_stage_tb.sv
`timescale 1ns/10ps

module exec_stage_tb;
   import rv_pkg::*;

   // directed tests take about 300 cycles
   localparam int test_cycles = 300;
   localparam int max_cycles = 2 * test_cycles + 100;

   logic        clk;
   logic        rstn;
   logic        issue;
   logic [31:0] instr;
   logic [31:0] pc;
   logic        mem_fwd_en;
   logic [4:0]  mem_fwd_rd;
   logic [31:0] mem_fwd_value;
   logic        completed;
   logic [31:0] result;
   logic [4:0]  rd_out;
   logic        illegal;

   int errors = 0;
   int checks = 0;
   int cyc = 0;

   // reference model state
   logic [31:0] shadow [32];
   logic [4:0]  prev_rd = 5'd0;
   logic [31:0] cur_pc = 32'h0000_1000;

   // expected completions, in issue order
   int          due_q [$];
   logic [31:0] exp_result_q [$];
   logic [4:0]  exp_rd_q [$];
   logic        exp_ill_q [$];

   exec_stage dut (
      .clk           (clk),
      .rstn          (rstn),
      .issue         (issue),
      .instr         (instr),
      .pc            (pc),
      .mem_fwd_en    (mem_fwd_en),
      .mem_fwd_rd    (mem_fwd_rd),
      .mem_fwd_value (mem_fwd_value),
      .completed     (completed),
      .result        (result),
      .rd_out        (rd_out),
      .illegal       (illegal)
   );

   bind exec_stage exec_stage_asserts u_asserts (
      .clk         (clk),
      .rstn        (rstn),
      .issue       (issue),
      .completed   (completed),
      .dec_illegal (dec_illegal),
      .wr_en       (wr_en),
      .rs1_idx     (rs1_idx),
      .rs1_value   (u_alu.a),
      .rs2_idx     (rs2_idx),
      .rs2_value   (u_alu.b)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cyc <= cyc + 1;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("CHECK FAILED t=%0t %s: got %h expected %h", $time, name, got, exp);
      end
   endtask

   // outputs compared in mid-cycle away from the driving edge
   always @(negedge clk) begin
      if (due_q.size() > 0 && due_q[0] == cyc) begin
         void'(due_q.pop_front());
         check_value("completed", completed, 32'd1);
         check_value("illegal", illegal, exp_ill_q[0]);
         check_value("rd_out", rd_out, exp_rd_q.pop_front());
         if (!exp_ill_q.pop_front()) begin
            check_value("result", result, exp_result_q[0]);
         end
         void'(exp_result_q.pop_front());
      end else begin
         check_value("completed", completed, 32'd0);
      end
   end

   // opcode, funct3 and funct7 per mnemonic
   function automatic logic [16:0] fields(input string mn);
      case (mn)
         "add": return {opc_op, 3'd0, funct7_base};
         "sub": return {opc_op, 3'd0, funct7_alt};
         "sll": return {opc_op, 3'd1, funct7_base};
         "slt": return {opc_op, 3'd2, funct7_base};
         "sltu": return {opc_op, 3'd3, funct7_base};
         "xor": return {opc_op, 3'd4, funct7_base};
         "srl": return {opc_op, 3'd5, funct7_base};
         "sra": return {opc_op, 3'd5, funct7_alt};
         "or": return {opc_op, 3'd6, funct7_base};
         "and": return {opc_op, 3'd7, funct7_base};
         "mul": return {opc_op, 3'd0, funct7_m};
         "mulh": return {opc_op, 3'd1, funct7_m};
         "mulhsu": return {opc_op, 3'd2, funct7_m};
         "mulhu": return {opc_op, 3'd3, funct7_m};
         "div": return {opc_op, 3'd4, funct7_m};
         "divu": return {opc_op, 3'd5, funct7_m};
         "rem": return {opc_op, 3'd6, funct7_m};
         "remu": return {opc_op, 3'd7, funct7_m};
         "addi": return {opc_op_imm, 3'd0, funct7_base};
         "slti": return {opc_op_imm, 3'd2, funct7_base};
         "sltiu": return {opc_op_imm, 3'd3, funct7_base};
         "xori": return {opc_op_imm, 3'd4, funct7_base};
         "ori": return {opc_op_imm, 3'd6, funct7_base};
         "andi": return {opc_op_imm, 3'd7, funct7_base};
         "slli": return {opc_op_imm, 3'd1, funct7_base};
         "srli": return {opc_op_imm, 3'd5, funct7_base};
         "srai": return {opc_op_imm, 3'd5, funct7_alt};
         "lb": return {opc_load, 3'd0, 7'd0};
         "lh": return {opc_load, 3'd1, 7'd0};
         "lw": return {opc_load, 3'd2, 7'd0};
         "lbu": return {opc_load, 3'd4, 7'd0};
         "lhu": return {opc_load, 3'd5, 7'd0};
         "sb": return {opc_store, 3'd0, 7'd0};
         "sh": return {opc_store, 3'd1, 7'd0};
         "sw": return {opc_store, 3'd2, 7'd0};
         "beq": return {opc_branch, 3'd0, 7'd0};
         "bne": return {opc_branch, 3'd1, 7'd0};
         "blt": return {opc_branch, 3'd4, 7'd0};
         "bge": return {opc_branch, 3'd5, 7'd0};
         "bltu": return {opc_branch, 3'd6, 7'd0};
         "bgeu": return {opc_branch, 3'd7, 7'd0};
         "lui": return {opc_lui, 3'd0, 7'd0};
         "auipc": return {opc_auipc, 3'd0, 7'd0};
         "jal": return {opc_jal, 3'd0, 7'd0};
         "jalr": return {opc_jalr, 3'd0, 7'd0};
         // unknown major opcode
         default: return {7'h7f, 3'd0, 7'd0};
      endcase
   endfunction

   function automatic logic [31:0] encode(input string mn, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2,
                                          input logic [31:0] imm);
      instr_word_u w;
      logic [16:0] code;
      logic [6:0]  opc;
      logic [2:0]  f3;
      logic [6:0]  f7;
      logic [11:0] imm12;
      code = fields(mn);
      opc = code[16:10];
      f3 = code[9:7];
      f7 = code[6:0];
      // shift immediates carry funct7 above the shift amount
      if (opc == opc_op_imm && (f3 == 3'd1 || f3 == 3'd5))
         imm12 = {f7, imm[4:0]};
      else
         imm12 = imm[11:0];
      case (opc)
         opc_op: w.r = '{f7, rs2, rs1, f3, rd, opc};
         opc_store: w.s = '{imm[11:5], rs2, rs1, f3, imm[4:0], opc};
         opc_branch: w.b = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
         opc_lui, opc_auipc: w.u = '{imm[31:12], rd, opc};
         opc_jal: w.j = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
         default: w.i = '{imm12, rs1, f3, rd, opc};
      endcase
      return w.raw;
   endfunction

   function automatic logic [31:0] model(input string mn, input logic [31:0] a,
                                         input logic [31:0] b, input logic [31:0] imm,
                                         input logic [31:0] at_pc);
      longint      sa;
      longint      sb;
      longint      ub;
      longint      pss;
      longint      psu;
      logic [63:0] puu;
      sa = longint'($signed(a));
      sb = longint'($signed(b));
      ub = {32'b0, b};
      pss = sa * sb;
      psu = sa * ub;
      puu = {32'b0, a} * {32'b0, b};
      case (mn)
         "lui": return imm;
         "auipc": return at_pc + imm;
         "jal", "jalr": return at_pc + 32'd4;
         "beq": return {31'b0, a == b};
         "bne": return {31'b0, a != b};
         "blt": return {31'b0, $signed(a) < $signed(b)};
         "bge": return {31'b0, $signed(a) >= $signed(b)};
         "bltu": return {31'b0, a < b};
         "bgeu": return {31'b0, a >= b};
         "addi", "lb", "lh", "lw", "lbu", "lhu", "sb", "sh", "sw": return a + imm;
         "add": return a + b;
         "sub": return a - b;
         "sll": return a << b[4:0];
         "slli": return a << imm[4:0];
         "slt": return {31'b0, $signed(a) < $signed(b)};
         "slti": return {31'b0, $signed(a) < $signed(imm)};
         "sltu": return {31'b0, a < b};
         "sltiu": return {31'b0, a < imm};
         "xor": return a ^ b;
         "xori": return a ^ imm;
         "or": return a | b;
         "ori": return a | imm;
         "and": return a & b;
         "andi": return a & imm;
         "srl": return a >> b[4:0];
         "srli": return a >> imm[4:0];
         "sra": return $signed(a) >>> b[4:0];
         "srai": return $signed(a) >>> imm[4:0];
         "mul": return pss[31:0];
         "mulh": return pss[63:32];
         "mulhsu": return psu[63:32];
         "mulhu": return puu[63:32];
         // min / -1 wraps to min in 64 bits and leaves remainder 0
         "div": return (b == '0) ? '1 : 32'(sa / sb);
         "divu": return (b == '0) ? '1 : a / b;
         "rem": return (b == '0) ? a : 32'(sa % sb);
         "remu": return (b == '0) ? a : a % b;
         default: return '0;
      endcase
   endfunction

   // architectural operand value seen by the next issue
   function automatic logic [31:0] operand(input logic [4:0] idx);
      if (idx == 5'd0)
         return '0;
      if (idx != prev_rd && mem_fwd_en && mem_fwd_rd == idx)
         return mem_fwd_value;
      return shadow[idx];
   endfunction

   task automatic issue_op(input string mn, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [4:0] rs2, input logic [31:0] imm);
      logic [6:0]  opc;
      logic        bad;
      logic [4:0]  wr;
      logic [31:0] res;
      @(posedge clk);
      opc = fields(mn) >> 10;
      bad = (mn == "bad");
      wr = (bad || opc == opc_branch || opc == opc_store) ? 5'd0 : rd;
      res = model(mn, operand(rs1), operand(rs2), imm, cur_pc);
      issue <= 1'b1;
      instr <= encode(mn, rd, rs1, rs2, imm);
      pc <= cur_pc;
      due_q.push_back(cyc + 2);
      exp_result_q.push_back(res);
      exp_rd_q.push_back(wr);
      exp_ill_q.push_back(bad);
      if (wr != 5'd0)
         shadow[wr] = res;
      prev_rd = wr;
      cur_pc = cur_pc + 32'd4;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         issue <= 1'b0;
         prev_rd = 5'd0;
      end
   endtask

   task automatic set_mem_fwd(input logic en, input logic [4:0] rd, input logic [31:0] value);
      @(posedge clk);
      issue <= 1'b0;
      mem_fwd_en <= en;
      mem_fwd_rd <= rd;
      mem_fwd_value <= value;
      prev_rd = 5'd0;
   endtask

   task automatic reset_dut();
      @(posedge clk);
      issue <= 1'b0;
      rstn <= 1'b1;
      repeat (2) @(posedge clk);
      rstn <= 1'b0;
      foreach (shadow[i])
         shadow[i] = '0;
      prev_rd = 5'd0;
   endtask

   // addi reads the lui result through self-forwarding
   task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
      logic [31:0] lo;
      lo = {{20{value[11]}}, value[11:0]};
      issue_op("lui", rd, 5'd0, 5'd0, value - lo);
      issue_op("addi", rd, rd, 5'd0, lo);
   endtask

   // add into x0 just reports the register
   task automatic read_all();
      for (int i = 1; i < 32; i++)
         issue_op("add", 5'd0, 5'(i), 5'd0, 32'd0);
   endtask

   task automatic test_alu_ops();
      string       r_ops [10] = '{"add", "sub", "sll", "slt", "sltu",
                                  "xor", "srl", "sra", "or", "and"};
      string       i_ops [9] = '{"addi", "slti", "sltiu", "xori", "ori",
                                 "andi", "slli", "srli", "srai"};
      int          pairs [4][2] = '{'{1, 2}, '{3, 1}, '{4, 3}, '{2, 4}};
      logic [31:0] r;
      load_const(5'd1, $urandom());
      load_const(5'd2, $urandom());
      load_const(5'd3, 32'h8000_0000);
      load_const(5'd4, 32'hffff_fffb);
      foreach (pairs[p]) begin
         foreach (r_ops[k])
            issue_op(r_ops[k], 5'd9, 5'(pairs[p][0]), 5'(pairs[p][1]), 32'd0);
         foreach (i_ops[k]) begin
            r = $urandom();
            issue_op(i_ops[k], 5'd10, 5'(pairs[p][0]), 5'd0, {{20{r[11]}}, r[11:0]});
         end
      end
      idle(1);
   endtask

   task automatic test_m_ext();
      string m_ops [8] = '{"mul", "mulh", "mulhsu", "mulhu", "div", "divu", "rem", "remu"};
      int    pairs [5][2] = '{'{11, 12}, '{12, 16}, '{11, 13}, '{14, 15}, '{15, 14}};
      load_const(5'd11, $urandom());
      load_const(5'd12, $urandom());
      load_const(5'd13, 32'd0);
      load_const(5'd14, 32'h8000_0000);
      load_const(5'd15, 32'hffff_ffff);
      load_const(5'd16, $urandom_range(255, 1));
      foreach (pairs[p]) begin
         foreach (m_ops[k])
            issue_op(m_ops[k], 5'd17, 5'(pairs[p][0]), 5'(pairs[p][1]), 32'd0);
      end
      idle(1);
   endtask

   task automatic test_forwarding();
      logic [31:0] v;
      v = $urandom();
      issue_op("addi", 5'd20, 5'd0, 5'd0, 32'd100);
      issue_op("add", 5'd21, 5'd20, 5'd20, 32'd0);
      issue_op("sub", 5'd22, 5'd21, 5'd20, 32'd0);
      issue_op("xor", 5'd23, 5'd22, 5'd21, 32'd0);
      set_mem_fwd(1'b1, 5'd20, v);
      issue_op("add", 5'd24, 5'd20, 5'd0, 32'd0);
      // own result beats the memory stage
      issue_op("addi", 5'd20, 5'd0, 5'd0, 32'd5);
      issue_op("add", 5'd25, 5'd20, 5'd20, 32'd0);
      idle(1);
      issue_op("add", 5'd26, 5'd20, 5'd0, 32'd0);
      set_mem_fwd(1'b1, 5'd0, v);
      issue_op("addi", 5'd0, 5'd0, 5'd0, 32'd7);
      issue_op("add", 5'd27, 5'd0, 5'd0, 32'd0);
      set_mem_fwd(1'b0, 5'd0, 32'd0);
      idle(1);
   endtask

   task automatic test_control();
      string       br_ops [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
      string       ls_ops [8] = '{"lb", "lh", "lw", "lbu", "lhu", "sb", "sh", "sw"};
      logic [31:0] r;
      load_const(5'd5, 32'hffff_fff0);
      load_const(5'd6, 32'h0000_0010);
      load_const(5'd7, $urandom());
      r = $urandom();
      issue_op("auipc", 5'd8, 5'd0, 5'd0, {r[31:12], 12'h000});
      r = $urandom();
      issue_op("jal", 5'd9, 5'd0, 5'd0, {{11{r[20]}}, r[20:1], 1'b0});
      r = $urandom();
      issue_op("jalr", 5'd10, 5'd7, 5'd0, {{20{r[11]}}, r[11:0]});
      // rd field of 7 must be ignored
      foreach (br_ops[k]) begin
         r = $urandom();
         issue_op(br_ops[k], 5'd7, 5'd5, 5'd6, {{19{r[12]}}, r[12:1], 1'b0});
         issue_op(br_ops[k], 5'd7, 5'd6, 5'd5, {{19{r[12]}}, r[12:1], 1'b0});
         issue_op(br_ops[k], 5'd7, 5'd5, 5'd5, {{19{r[12]}}, r[12:1], 1'b0});
      end
      foreach (ls_ops[k]) begin
         r = $urandom();
         issue_op(ls_ops[k], 5'd11, 5'd7, 5'd6, {{20{r[11]}}, r[11:0]});
      end
      idle(1);
      read_all();
   endtask

   task automatic test_illegal_reset();
      issue_op("bad", 5'd3, 5'd1, 5'd2, 32'd0);
      idle(1);
      read_all();
      reset_dut();
      idle(2);
      read_all();
   endtask

   initial begin
      void'($urandom(32'haa99));
      rstn = 1'b1;
      issue = 1'b0;
      instr = '0;
      pc = '0;
      mem_fwd_en = 1'b0;
      mem_fwd_rd = '0;
      mem_fwd_value = '0;
      foreach (shadow[i])
         shadow[i] = '0;
      repeat (2) @(posedge clk);
      rstn <= 1'b0;
      test_alu_ops();
      test_m_ext();
      test_forwarding();
      test_control();
      test_illegal_reset();
      idle(3);
      errors = errors + dut.u_asserts.fails;
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   initial begin
      wait (cyc >= max_cycles);
      $display("timeout: run still going after %0d cycles", cyc);
      $display("checks: %0d, errors: %0d", checks, errors + 1);
      $display("Finished with errors");
      $finish;
   end

endmodule

// File: vlog.f
source/rv_pkg.sv
source/instr_decoder.sv
source/register_file.sv
source/exec_alu.sv
source/exec_stage.sv
verification/exec_stage_asserts.sv
verification/exec_stage_tb.sv
